// File: Makefile
# Verilator build for the capture target and its testbench

VERILATOR  ?= verilator
TOP        ?= tb_cw_target
RTL_TOP    ?= cw_target_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --timing --assert
VFLAGS     ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(filter design/%,$(SRCS)) --top-module $(RTL_TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
design/cw_pkg.sv
design/usb_reg_fe.sv
design/crypt_regs.sv
design/block_cipher.sv
design/cw_target_top.sv
test/tb_cw_target.sv

// File: design/block_cipher.sv
`timescale 1ns/1ps
`default_nettype none

module block_cipher (
   input  wire                            crypt_clk,
   input  wire                            rst,
   input  wire                            start,
   input  wire  [cw_pkg::BLOCK_WIDTH-1:0] key,
   input  wire  [cw_pkg::BLOCK_WIDTH-1:0] text_in,
   output wire  [cw_pkg::BLOCK_WIDTH-1:0] cipher_out,
   output wire                            busy,
   output logic                           done
);

   cw_pkg::crypt_state_e               state_q;
   logic [cw_pkg::ROUND_CNT_WIDTH-1:0] round_q;
   logic [cw_pkg::BLOCK_WIDTH-1:0]     data_q;   // Round state
   logic [cw_pkg::BLOCK_WIDTH-1:0]     key_q;    // Key frozen for the run
   logic                               load;

   // One round, key mix then rotate then index into the low byte
   function automatic logic [cw_pkg::BLOCK_WIDTH-1:0] round_fn(
      input logic [cw_pkg::BLOCK_WIDTH-1:0]     blk,
      input logic [cw_pkg::BLOCK_WIDTH-1:0]     k,
      input logic [cw_pkg::ROUND_CNT_WIDTH-1:0] idx
   );
      logic [2*cw_pkg::BLOCK_WIDTH-1:0] wide;
      logic [cw_pkg::BLOCK_WIDTH-1:0]   mix;
      wide = {k, k} << (8 * idx);                       // Round key, key rotated left 8*idx
      mix  = blk ^ wide[2*cw_pkg::BLOCK_WIDTH-1 -: cw_pkg::BLOCK_WIDTH];
      mix  = {mix[cw_pkg::BLOCK_WIDTH-2:0], mix[cw_pkg::BLOCK_WIDTH-1]};   // Rotate left by 1
      mix[7:0] = mix[7:0] ^ 8'(idx);
      return mix;
   endfunction

   assign load = (state_q == cw_pkg::CS_IDLE) && start;

   // Control FSM
   always_ff @(posedge crypt_clk) begin
      if (rst) begin
         state_q <= cw_pkg::CS_IDLE;
         round_q <= '0;
         done    <= 1'b0;
      end else begin
         done <= 1'b0;   // Single-cycle pulse
         case (state_q)
            cw_pkg::CS_IDLE: begin
               if (start) begin
                  state_q <= cw_pkg::CS_RUN;
                  round_q <= '0;
               end
            end
            cw_pkg::CS_RUN: begin
               round_q <= round_q + 1'b1;
               if (round_q == cw_pkg::LAST_ROUND) begin
                  state_q <= cw_pkg::CS_IDLE;
                  done    <= 1'b1;   // Lands as busy drops
               end
            end
            default: state_q <= cw_pkg::CS_IDLE;
         endcase
      end
   end

   // Datapath
   always_ff @(posedge crypt_clk) begin
      if (load) begin
         data_q <= text_in;
         key_q  <= key;
      end else if (state_q == cw_pkg::CS_RUN) begin
         data_q <= round_fn(data_q, key_q, round_q);
      end
   end

   assign busy       = (state_q == cw_pkg::CS_RUN);
   assign cipher_out = data_q;   // Valid from the done cycle

   a_busy_done_excl: assert property (@(posedge crypt_clk) disable iff (rst)
      !(busy && done))
      else $error("block_cipher: busy and done overlap");

   // Trigger window length seen by the scope
   a_busy_len: assert property (@(posedge crypt_clk) disable iff (rst)
      $rose(busy) |-> busy [*cw_pkg::ROUNDS] ##1 !busy)
      else $error("block_cipher: busy not %0d cycles", cw_pkg::ROUNDS);

endmodule

`default_nettype wire

// File: design/crypt_regs.sv
`timescale 1ns/1ps
`default_nettype none

module crypt_regs (
   input  wire                               crypt_clk,
   input  wire                               rst,
   input  wire  [cw_pkg::REG_ADDR_WIDTH-1:0] reg_address,
   input  wire  [cw_pkg::BYTECNT_SIZE-1:0]   reg_bytecnt,
   input  wire  [7:0]                        reg_datao,
   input  wire                               reg_read,
   input  wire                               reg_write,
   output logic [7:0]                        read_data,
   input  wire                               exttrigger_in,
   input  wire  [cw_pkg::BLOCK_WIDTH-1:0]    cipher_in,
   input  wire                               busy,
   input  wire                               done,
   output wire  [cw_pkg::BLOCK_WIDTH-1:0]    key,
   output wire  [cw_pkg::BLOCK_WIDTH-1:0]    text_out,
   output logic                              start,
   output wire                               user_led
);

   cw_pkg::reg_addr_e              reg_sel;
   logic [cw_pkg::BLOCK_WIDTH-1:0] key_q;
   logic [cw_pkg::BLOCK_WIDTH-1:0] text_q;
   logic [cw_pkg::BLOCK_WIDTH-1:0] cipher_q;   // Last ciphertext
   logic                           led_q;
   logic                           done_seen;  // Sticky until next start
   logic                           trig_q;     // Trigger level last cycle
   logic                           go_wr;
   logic                           trig_rise;
   logic [7:0]                     status_byte;

   // Byte n lives at bits 8n+7:8n
   function automatic logic [7:0] byte_sel(
      input logic [cw_pkg::BLOCK_WIDTH-1:0]  blk,
      input logic [cw_pkg::BYTECNT_SIZE-1:0] idx
   );
      return blk[idx*8 +: 8];
   endfunction

   assign reg_sel = cw_pkg::reg_addr_e'(reg_address);

   // Host writes into key, plaintext and LED
   always_ff @(posedge crypt_clk) begin
      if (rst) begin
         key_q  <= '0;
         text_q <= '0;
         led_q  <= 1'b0;
      end else if (reg_write) begin
         case (reg_sel)
            cw_pkg::REG_USER_LED: led_q <= reg_datao[0];
            cw_pkg::REG_KEY:      key_q[reg_bytecnt*8 +: 8]  <= reg_datao;
            cw_pkg::REG_TEXTIN:   text_q[reg_bytecnt*8 +: 8] <= reg_datao;
            default: ;            // Read-only and unmapped, write dropped
         endcase
      end
   end

   // Result capture from the cipher
   always_ff @(posedge crypt_clk) begin
      if (rst) begin
         cipher_q  <= '0;
         done_seen <= 1'b0;
      end else begin
         if (done) cipher_q <= cipher_in;
         if (start) begin
            done_seen <= 1'b0;   // New run, old result stale
         end else if (done) begin
            done_seen <= 1'b1;
         end
      end
   end

   // Start sources
   assign go_wr     = reg_write && (reg_sel == cw_pkg::REG_GO);
   assign trig_rise = exttrigger_in && !trig_q;   // Rising edge of the host trigger

   always_ff @(posedge crypt_clk) begin
      if (rst) begin
         trig_q <= 1'b0;
         start  <= 1'b0;
      end else begin
         trig_q <= exttrigger_in;
         // Dropped while running or already starting
         start  <= (go_wr || trig_rise) && !busy && !start;
      end
   end

   assign status_byte = {6'b0, done_seen, busy};

   // Read mux, quiet outside a read pulse
   always_comb begin
      read_data = 8'h00;
      if (reg_read) begin
         case (reg_sel)
            cw_pkg::REG_USER_LED:  read_data = {7'b0, led_q};
            cw_pkg::REG_STATUS:    read_data = status_byte;
            cw_pkg::REG_KEY:       read_data = byte_sel(key_q, reg_bytecnt);
            cw_pkg::REG_TEXTIN:    read_data = byte_sel(text_q, reg_bytecnt);
            cw_pkg::REG_CIPHEROUT: read_data = byte_sel(cipher_q, reg_bytecnt);
            cw_pkg::REG_IDENT:     read_data = cw_pkg::IDENT_VALUE;
            default:               read_data = 8'h00;   // Go and unmapped
         endcase
      end
   end

   assign key      = key_q;
   assign text_out = text_q;
   assign user_led = led_q;

   // Busy comes from the cipher a cycle after start, so the gate must hold
   a_no_start_busy: assert property (@(posedge crypt_clk) disable iff (rst)
      !(start && busy))
      else $error("crypt_regs: start issued while cipher busy");

endmodule

`default_nettype wire

// File: design/cw_pkg.sv
`default_nettype none

package cw_pkg;

   // Host bus geometry
   localparam int ADDR_WIDTH     = 8;
   localparam int BYTECNT_SIZE   = 4;                          // Byte select inside a register
   localparam int REG_ADDR_WIDTH = ADDR_WIDTH - BYTECNT_SIZE;  // Register select

   // Cipher dimensions
   localparam int BLOCK_WIDTH     = 128;    // Key, plaintext and ciphertext
   localparam int ROUNDS          = 16;
   localparam int ROUND_CNT_WIDTH = $clog2(ROUNDS);

   // Index of the final round, typed to match the round counter
   localparam logic [ROUND_CNT_WIDTH-1:0] LAST_ROUND = ROUND_CNT_WIDTH'(ROUNDS - 1);

   // Fixed byte for the ident register
   localparam logic [7:0] IDENT_VALUE = 8'hC5;

   // Register map, upper address bits
   typedef enum logic [REG_ADDR_WIDTH-1:0] {
      REG_USER_LED  = 4'd0,    // Bit 0 drives the LED
      REG_STATUS    = 4'd1,    // Read only, busy and done-seen
      REG_KEY       = 4'd2,
      REG_TEXTIN    = 4'd3,
      REG_CIPHEROUT = 4'd4,    // Read only
      REG_GO        = 4'd5,    // Any write starts a run
      REG_IDENT     = 4'd6     // Read only
   } reg_addr_e;

   // Cipher control
   typedef enum logic {
      CS_IDLE = 1'b0,
      CS_RUN  = 1'b1
   } crypt_state_e;

endpackage

`default_nettype wire

// File: design/cw_target_top.sv
`timescale 1ns/1ps
`default_nettype none

module cw_target_top (
   input  wire                          crypt_clk,
   input  wire                          rst,
   input  wire [cw_pkg::ADDR_WIDTH-1:0] usb_addr,
   input  wire [7:0]                    usb_din,
   output wire [7:0]                    usb_dout,
   output wire                          usb_isout,   // Board wrapper enables the tristate
   input  wire                          usb_cen,
   input  wire                          usb_rdn,
   input  wire                          usb_wrn,
   input  wire                          usb_trigger,
   output wire                          tio_trigger, // Scope capture window
   output wire                          led3
);

   wire [cw_pkg::REG_ADDR_WIDTH-1:0] reg_address;
   wire [cw_pkg::BYTECNT_SIZE-1:0]   reg_bytecnt;
   wire [7:0]                        reg_datao;
   wire [7:0]                        read_data;
   wire                              reg_read;
   wire                              reg_write;
   wire [cw_pkg::BLOCK_WIDTH-1:0]    crypt_key;
   wire [cw_pkg::BLOCK_WIDTH-1:0]    crypt_text;
   wire [cw_pkg::BLOCK_WIDTH-1:0]    crypt_cipher;
   wire                              crypt_start;
   wire                              crypt_busy;
   wire                              crypt_done;

   usb_reg_fe u_reg_fe (
      .crypt_clk   (crypt_clk),
      .rst         (rst),
      .usb_addr    (usb_addr),
      .usb_din     (usb_din),
      .usb_dout    (usb_dout),
      .usb_isout   (usb_isout),
      .usb_cen     (usb_cen),
      .usb_rdn     (usb_rdn),
      .usb_wrn     (usb_wrn),
      .reg_address (reg_address),
      .reg_bytecnt (reg_bytecnt),
      .reg_datao   (reg_datao),
      .read_data   (read_data),
      .reg_read    (reg_read),
      .reg_write   (reg_write)
   );

   crypt_regs u_regs (
      .crypt_clk     (crypt_clk),
      .rst           (rst),
      .reg_address   (reg_address),
      .reg_bytecnt   (reg_bytecnt),
      .reg_datao     (reg_datao),
      .reg_read      (reg_read),
      .reg_write     (reg_write),
      .read_data     (read_data),
      .exttrigger_in (usb_trigger),    // Host trigger, edge starts a run
      .cipher_in     (crypt_cipher),
      .busy          (crypt_busy),
      .done          (crypt_done),
      .key           (crypt_key),
      .text_out      (crypt_text),
      .start         (crypt_start),
      .user_led      (led3)
   );

   block_cipher u_cipher (
      .crypt_clk  (crypt_clk),
      .rst        (rst),
      .start      (crypt_start),
      .key        (crypt_key),
      .text_in    (crypt_text),
      .cipher_out (crypt_cipher),
      .busy       (crypt_busy),
      .done       (crypt_done)
   );

   assign tio_trigger = crypt_busy;   // High for the whole run

endmodule

`default_nettype wire

// File: design/usb_reg_fe.sv
`timescale 1ns/1ps
`default_nettype none

module usb_reg_fe (
   input  wire                               crypt_clk,
   input  wire                               rst,
   input  wire  [cw_pkg::ADDR_WIDTH-1:0]     usb_addr,
   input  wire  [7:0]                        usb_din,
   output logic [7:0]                        usb_dout,
   output wire                               usb_isout,
   input  wire                               usb_cen,
   input  wire                               usb_rdn,
   input  wire                               usb_wrn,
   output wire  [cw_pkg::REG_ADDR_WIDTH-1:0] reg_address,
   output wire  [cw_pkg::BYTECNT_SIZE-1:0]   reg_bytecnt,
   output wire  [7:0]                        reg_datao,
   input  wire  [7:0]                        read_data,
   output wire                               reg_read,
   output wire                               reg_write
);

   logic [cw_pkg::ADDR_WIDTH-1:0] addr_q;   // Held for the whole strobe
   logic [7:0]                    din_q;
   logic                          rd_en_q;  // Sampled combined read enable
   logic                          rd_en_qq;
   logic                          wr_en_q;  // Sampled combined write enable
   logic                          wr_en_qq;
   logic                          rd_en_in;
   logic                          wr_en_in;
   logic                          bus_start;

   // Chip enable qualifies both strobes
   assign rd_en_in = ~usb_cen & ~usb_rdn;
   assign wr_en_in = ~usb_cen & ~usb_wrn;

   // New access seen on the pins while the bus was quiet last cycle
   assign bus_start = (rd_en_in | wr_en_in) & ~(rd_en_q | wr_en_q);

   always_ff @(posedge crypt_clk) begin
      if (rst) begin
         rd_en_q  <= 1'b0;
         rd_en_qq <= 1'b0;
         wr_en_q  <= 1'b0;
         wr_en_qq <= 1'b0;
      end else begin
         rd_en_q  <= rd_en_in;
         rd_en_qq <= rd_en_q;
         wr_en_q  <= wr_en_in;
         wr_en_qq <= wr_en_q;
      end
   end

   // Address and data captured on the same edge as the enables
   always_ff @(posedge crypt_clk) begin
      if (bus_start) begin
         addr_q <= usb_addr;
         din_q  <= usb_din;
      end
   end

   // One pulse per strobe, a held strobe only fires once
   assign reg_read  = rd_en_q & ~rd_en_qq;
   assign reg_write = wr_en_q & ~wr_en_qq;

   assign reg_address = addr_q[cw_pkg::ADDR_WIDTH-1:cw_pkg::BYTECNT_SIZE];
   assign reg_bytecnt = addr_q[cw_pkg::BYTECNT_SIZE-1:0];
   assign reg_datao   = din_q;

   // Read byte held until the next read pulse
   always_ff @(posedge crypt_clk) begin
      if (reg_read) usb_dout <= read_data;
   end

   assign usb_isout = rd_en_q;   // Drive the bus while read is sampled low

   // Host must never assert both strobes in one access
   a_rd_wr_excl: assert property (@(posedge crypt_clk) disable iff (rst)
      !(reg_read && reg_write))
      else $error("usb_reg_fe: read and write pulses overlap");

endmodule

`default_nettype wire

// File: test/tb_cw_target.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cw_target;

   localparam int DRIVE_DLY         = 1;     // ns after the rising edge
   localparam int N_TESTS           = 14;
   localparam int ACCESS_CYCLES     = 20;    // Budget per bus access
   localparam int RUN_CYCLES        = 40;    // Budget per encryption
   localparam int ACCESSES_PER_TEST = 70;
   localparam int WATCHDOG_CYCLES   =
      N_TESTS * (ACCESSES_PER_TEST * ACCESS_CYCLES + RUN_CYCLES) + 2000;
   localparam int MAX_POLLS         = 50;

   logic                          crypt_clk;
   logic                          rst;
   logic [cw_pkg::ADDR_WIDTH-1:0] usb_addr;
   logic [7:0]                    usb_din;
   wire  [7:0]                    usb_dout;
   wire                           usb_isout;
   logic                          usb_cen;
   logic                          usb_rdn;
   logic                          usb_wrn;
   logic                          usb_trigger;
   wire                           tio_trigger;
   wire                           led3;

   int n_err      = 0;
   int n_pass     = 0;
   int n_fail     = 0;
   int err_mark   = 0;    // Error count when the current test began
   int run_len    = 0;    // Cycles of the trigger window in progress
   int last_len   = 0;    // Length of the last finished window
   int busy_rises = 0;

   cw_target_top dut (
      .crypt_clk   (crypt_clk),
      .rst         (rst),
      .usb_addr    (usb_addr),
      .usb_din     (usb_din),
      .usb_dout    (usb_dout),
      .usb_isout   (usb_isout),
      .usb_cen     (usb_cen),
      .usb_rdn     (usb_rdn),
      .usb_wrn     (usb_wrn),
      .usb_trigger (usb_trigger),
      .tio_trigger (tio_trigger),
      .led3        (led3)
   );

   initial begin
      crypt_clk = 1'b0;
      forever #4 crypt_clk = ~crypt_clk;
   end

   // Trigger window length and run count
   always @(posedge crypt_clk) begin
      if (rst) begin
         run_len    <= 0;
         busy_rises <= 0;
      end else if (tio_trigger) begin
         run_len <= run_len + 1;
         if (run_len == 0) busy_rises <= busy_rises + 1;
      end else if (run_len != 0) begin
         last_len <= run_len;   // Window just closed
         run_len  <= 0;
      end
   end

   a_trig_window: assert property (@(posedge crypt_clk) disable iff (rst)
      $rose(tio_trigger) |-> tio_trigger [*cw_pkg::ROUNDS] ##1 !tio_trigger)
      else begin
         n_err++;
         $display("tio_trigger window was not %0d cycles long", cw_pkg::ROUNDS);
      end

   // Bus released means output enable drops one cycle later
   a_isout_quiet: assert property (@(posedge crypt_clk) disable iff (rst)
      $past(usb_rdn) |-> !usb_isout)
      else begin
         n_err++;
         $display("usb_isout high although the read strobe was released");
      end

   function automatic logic [cw_pkg::ADDR_WIDTH-1:0] addr_of(
      input logic [cw_pkg::REG_ADDR_WIDTH-1:0] r,
      input int                                n
   );
      logic [cw_pkg::BYTECNT_SIZE-1:0] b;
      b = n[cw_pkg::BYTECNT_SIZE-1:0];
      return {r, b};
   endfunction

   function automatic logic [cw_pkg::BLOCK_WIDTH-1:0] rand_block();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   // Reference model with the round key as key rotated left 8*i
   function automatic logic [cw_pkg::BLOCK_WIDTH-1:0] ref_cipher(
      input logic [cw_pkg::BLOCK_WIDTH-1:0] k,
      input logic [cw_pkg::BLOCK_WIDTH-1:0] p
   );
      logic [cw_pkg::BLOCK_WIDTH-1:0] s;
      logic [cw_pkg::BLOCK_WIDTH-1:0] rk;
      s = p;
      for (int i = 0; i < cw_pkg::ROUNDS; i++) begin
         rk = (i == 0) ? k : ((k << (8 * i)) | (k >> (cw_pkg::BLOCK_WIDTH - 8 * i)));
         s  = s ^ rk;
         s  = {s[cw_pkg::BLOCK_WIDTH-2:0], s[cw_pkg::BLOCK_WIDTH-1]};   // Rotate left 1
         s[7:0] = s[7:0] ^ 8'(i);
      end
      return s;
   endfunction

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp) else begin
         n_err++;
         $display("mismatch %s expected %02h actual %02h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      assert (act == exp) else begin
         n_err++;
         $display("mismatch %s expected %0d actual %0d", name, exp, act);
      end
   endtask

   // Entered and left 1 ns after an edge
   task automatic write_byte(
      input logic [cw_pkg::REG_ADDR_WIDTH-1:0] r,
      input int                                n,
      input logic [7:0]                        d,
      input int                                hold
   );
      usb_addr = addr_of(r, n);
      usb_din  = d;
      usb_cen  = 1'b0;
      usb_wrn  = 1'b0;
      repeat (hold) @(posedge crypt_clk);
      #DRIVE_DLY;
      usb_cen = 1'b1;
      usb_wrn = 1'b1;
      repeat (2) @(posedge crypt_clk);   // Let the enable pipeline drain
      #DRIVE_DLY;
   endtask

   task automatic read_byte(
      input  string                               name,
      input  logic [cw_pkg::REG_ADDR_WIDTH-1:0] r,
      input  int                                n,
      output logic [7:0]                        d
   );
      usb_addr = addr_of(r, n);
      usb_cen  = 1'b0;
      usb_rdn  = 1'b0;
      repeat (3) @(posedge crypt_clk);
      #DRIVE_DLY;
      d = usb_dout;
      assert (usb_isout === 1'b1) else begin
         n_err++;
         $display("%s: usb_isout low while a read was in progress", name);
      end
      usb_cen = 1'b1;
      usb_rdn = 1'b1;
      repeat (2) @(posedge crypt_clk);
      #DRIVE_DLY;
   endtask

   task automatic load_block(
      input logic [cw_pkg::REG_ADDR_WIDTH-1:0] r,
      input logic [cw_pkg::BLOCK_WIDTH-1:0]    blk
   );
      for (int n = 0; n < 16; n++) write_byte(r, n, blk[8*n +: 8], 2);
   endtask

   task automatic pulse_trigger();
      usb_trigger = 1'b1;
      repeat (2) @(posedge crypt_clk);
      #DRIVE_DLY;
      usb_trigger = 1'b0;
      repeat (2) @(posedge crypt_clk);
      #DRIVE_DLY;
   endtask

   // Poll status until done-seen
   task automatic wait_done(input string name);
      logic [7:0] st;
      bit         seen;
      seen = 1'b0;
      st   = 8'h00;
      for (int polls = 0; polls < MAX_POLLS && !seen; polls++) begin
         read_byte(name, cw_pkg::REG_STATUS, 0, st);
         seen = st[1];
      end
      assert (seen) else begin
         n_err++;
         $display("%s: done-seen not set after %0d status polls", name, MAX_POLLS);
      end
      check_byte(name, 8'h02, st);   // Idle with result flagged
   endtask

   task automatic check_cipher(input string name, input logic [cw_pkg::BLOCK_WIDTH-1:0] exp);
      logic [7:0] b;
      for (int n = 0; n < 16; n++) begin
         read_byte(name, cw_pkg::REG_CIPHEROUT, n, b);
         check_byte(name, exp[8*n +: 8], b);
      end
   endtask

   task automatic run_and_check(input string name, input bit use_trig);
      logic [cw_pkg::BLOCK_WIDTH-1:0] k;
      logic [cw_pkg::BLOCK_WIDTH-1:0] p;
      int                             rises0;
      k = rand_block();
      p = rand_block();
      load_block(cw_pkg::REG_KEY, k);
      load_block(cw_pkg::REG_TEXTIN, p);
      rises0 = busy_rises;
      if (use_trig) pulse_trigger();
      else write_byte(cw_pkg::REG_GO, 0, 8'h01, 2);
      wait_done(name);
      check_cipher(name, ref_cipher(k, p));
      check_count(name, 1, busy_rises - rises0);
      check_count(name, cw_pkg::ROUNDS, last_len);
   endtask

   task automatic end_test(input string name);
      if (n_err == err_mark) begin
         n_pass++;
         $display("PASS %s", name);
      end else begin
         n_fail++;
         $display("FAIL %s with %0d errors", name, n_err - err_mark);
      end
      err_mark = n_err;
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge crypt_clk);
      $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      string                          name;
      logic [7:0]                     b;
      logic [cw_pkg::BLOCK_WIDTH-1:0] k;
      logic [cw_pkg::BLOCK_WIDTH-1:0] p;
      int                             rises0;
      void'($urandom(32'he9d8));
      rst         = 1'b1;
      usb_addr    = '0;
      usb_din     = 8'h00;
      usb_cen     = 1'b1;
      usb_rdn     = 1'b1;
      usb_wrn     = 1'b1;
      usb_trigger = 1'b0;
      repeat (5) @(posedge crypt_clk);
      #DRIVE_DLY;
      rst = 1'b0;

      name = "reset_defaults";
      read_byte(name, cw_pkg::REG_IDENT, 0, b);
      check_byte(name, cw_pkg::IDENT_VALUE, b);
      read_byte(name, cw_pkg::REG_STATUS, 0, b);
      check_byte(name, 8'h00, b);
      check_byte(name, 8'h00, {7'b0, led3});
      check_byte(name, 8'h00, {7'b0, tio_trigger});
      write_byte(4'hA, 3, 8'h5A, 2);   // Unmapped so the write is dropped
      read_byte(name, 4'hA, 3, b);
      check_byte(name, 8'h00, b);
      end_test(name);

      name = "key_text_readback";
      k = rand_block();
      p = rand_block();
      load_block(cw_pkg::REG_KEY, k);
      load_block(cw_pkg::REG_TEXTIN, p);
      for (int n = 0; n < 16; n++) begin
         read_byte(name, cw_pkg::REG_KEY, n, b);
         check_byte(name, k[8*n +: 8], b);
         read_byte(name, cw_pkg::REG_TEXTIN, n, b);
         check_byte(name, p[8*n +: 8], b);
      end
      end_test(name);

      name = "led_follow";
      write_byte(cw_pkg::REG_USER_LED, 0, 8'hFF, 2);
      check_byte(name, 8'h01, {7'b0, led3});
      write_byte(cw_pkg::REG_USER_LED, 0, 8'hFE, 2);   // Bit 0 clear
      check_byte(name, 8'h00, {7'b0, led3});
      end_test(name);

      for (int i = 0; i < 8; i++) begin
         name = $sformatf("go_encrypt_%0d", i);
         run_and_check(name, 1'b0);
         end_test(name);
      end

      name = "trigger_encrypt";
      run_and_check(name, 1'b1);
      end_test(name);

      name = "busy_retrigger";
      k = rand_block();
      p = rand_block();
      load_block(cw_pkg::REG_KEY, k);
      load_block(cw_pkg::REG_TEXTIN, p);
      rises0 = busy_rises;
      write_byte(cw_pkg::REG_GO, 0, 8'h01, 2);
      check_byte(name, 8'h01, {7'b0, tio_trigger});   // Run under way
      write_byte(cw_pkg::REG_GO, 0, 8'h01, 2);
      pulse_trigger();
      wait_done(name);
      check_cipher(name, ref_cipher(k, p));
      check_count(name, 1, busy_rises - rises0);
      check_count(name, cw_pkg::ROUNDS, last_len);
      end_test(name);

      name = "held_strobe";
      k = rand_block();
      p = rand_block();
      load_block(cw_pkg::REG_KEY, k);
      load_block(cw_pkg::REG_TEXTIN, p);
      rises0 = busy_rises;
      write_byte(cw_pkg::REG_GO, 0, 8'h01, 40);   // Strobe outlasts a whole run
      check_count(name, 1, busy_rises - rises0);
      wait_done(name);
      check_cipher(name, ref_cipher(k, p));
      end_test(name);

      $display("%0d tests: %0d passed, %0d failed, %0d check errors",
               n_pass + n_fail, n_pass, n_fail, n_err);
      if (n_err == 0 && n_fail == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
